// File: src/scr1_mem_pkg.sv
// Shared definitions for the data memory subsystem
// Widths, request/response payloads and Wishbone bundles
// Timer address window, register offsets and reset values

package scr1_mem_pkg;

    //------------------------------------------------------------
    // Plain vector types
    //------------------------------------------------------------
    typedef logic [31:0] dmem_addr_t;   // Byte address
    typedef logic [31:0] dmem_data_t;   // Data word
    typedef logic [3:0]  byte_sel_t;    // One bit per byte lane
    typedef logic [63:0] mtime_t;       // Timer value

    //------------------------------------------------------------
    // Encodings
    //------------------------------------------------------------
    typedef enum logic {
        MEM_CMD_RD = 1'b0,
        MEM_CMD_WR = 1'b1
    } mem_cmd_e;

    typedef enum logic [1:0] {
        MEM_WIDTH_BYTE  = 2'b00,
        MEM_WIDTH_HWORD = 2'b01,
        MEM_WIDTH_WORD  = 2'b10
    } mem_width_e;

    typedef enum logic [1:0] {
        MEM_RESP_NOTRDY = 2'b00,        // Idle or still waiting
        MEM_RESP_RDY_OK = 2'b01,
        MEM_RESP_RDY_ER = 2'b10
    } mem_resp_e;

    // Bridge FSM
    typedef enum logic [1:0] {
        BR_IDLE = 2'b00,                // Ready for a request
        BR_BUS  = 2'b01,                // Bus cycle in flight
        BR_RESP = 2'b10                 // Response to the core
    } bridge_state_e;

    //------------------------------------------------------------
    // Bundles
    //------------------------------------------------------------
    typedef struct packed {
        mem_cmd_e   cmd;
        mem_width_e width;
        dmem_addr_t addr;
        dmem_data_t wdata;
    } dmem_req_t;                       // 67 bits

    typedef struct packed {
        dmem_data_t rdata;
        mem_resp_e  resp;
    } dmem_rsp_t;                       // 34 bits

    typedef struct packed {
        logic       stb;
        logic       we;
        dmem_addr_t adr;
        dmem_data_t dat;
        byte_sel_t  sel;
    } wb_m2s_t;                         // 70 bits, master side

    typedef struct packed {
        dmem_data_t dat;
        logic       ack;
        logic       err;
    } wb_s2m_t;                         // 34 bits, slave side

    // Timer window, 32 bytes
    localparam dmem_addr_t TIMER_ADDR_MASK    = 32'hFFFF_FFE0;
    localparam dmem_addr_t TIMER_ADDR_PATTERN = 32'hF004_0000;

    // Timer register offsets
    localparam logic [4:0] TIMER_OFS_CTRL        = 5'h00;  // Bit 0 enables counting
    localparam logic [4:0] TIMER_OFS_MTIME_LO    = 5'h08;
    localparam logic [4:0] TIMER_OFS_MTIME_HI    = 5'h0C;
    localparam logic [4:0] TIMER_OFS_MTIMECMP_LO = 5'h10;
    localparam logic [4:0] TIMER_OFS_MTIMECMP_HI = 5'h14;

    // Timer reset values
    localparam mtime_t MTIMECMP_RST = 64'hFFFF_FFFF_FFFF_FFFF;
    localparam mtime_t MTIME_RST    = 64'h0;

endpackage : scr1_mem_pkg

// File: src/dmem_router.sv
// Data memory router
// Timer window decode, request steering, response return path

`timescale 1ns/1ns

module dmem_router (
    input  logic                    core_clk_i,
    input  logic                    arst_n_i,
    // Core side
    input  logic                    core_req_i,
    input  scr1_mem_pkg::dmem_req_t core_pl_i,
    output logic                    core_req_ack_o,
    output scr1_mem_pkg::dmem_rsp_t core_rsp_o,
    // Shared payload to both targets
    output scr1_mem_pkg::dmem_req_t tgt_pl_o,
    // Timer port
    output logic                    tmr_req_o,
    input  logic                    tmr_req_ack_i,
    input  scr1_mem_pkg::dmem_rsp_t tmr_rsp_i,
    // Bus bridge port
    output logic                    bus_req_o,
    input  logic                    bus_req_ack_i,
    input  scr1_mem_pkg::dmem_rsp_t bus_rsp_i
);

//------------------------------------------------------------
// Decode
//------------------------------------------------------------
logic                    hit_tmr;       // Address falls in timer window
logic                    busy_q;        // Transaction outstanding
logic                    sel_tmr_q;     // Outstanding one went to the timer
logic                    accept;
scr1_mem_pkg::dmem_rsp_t sel_rsp;       // Response of the owning port
logic                    rsp_done;

assign hit_tmr = (core_pl_i.addr & scr1_mem_pkg::TIMER_ADDR_MASK)
                 == scr1_mem_pkg::TIMER_ADDR_PATTERN;

assign tgt_pl_o  = core_pl_i;           // Both targets see the payload
assign tmr_req_o = core_req_i & ~busy_q &  hit_tmr;
assign bus_req_o = core_req_i & ~busy_q & ~hit_tmr;

// Ack only from the target that got the request
assign core_req_ack_o = core_req_i & ~busy_q & (hit_tmr ? tmr_req_ack_i : bus_req_ack_i);
assign accept         = core_req_i & core_req_ack_o;

//------------------------------------------------------------
// Response steering
//------------------------------------------------------------
assign sel_rsp  = sel_tmr_q ? tmr_rsp_i : bus_rsp_i;
assign rsp_done = busy_q & (sel_rsp.resp != scr1_mem_pkg::MEM_RESP_NOTRDY);

always_comb begin
    core_rsp_o.rdata = sel_rsp.rdata;
    // Hide anything from a port that has nothing outstanding
    core_rsp_o.resp  = busy_q ? sel_rsp.resp : scr1_mem_pkg::MEM_RESP_NOTRDY;
end

// Outstanding flag and owner
always_ff @(posedge core_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
        busy_q    <= 1'b0;
        sel_tmr_q <= 1'b0;
    end else begin
        if (accept) begin
            busy_q    <= 1'b1;
            sel_tmr_q <= hit_tmr;       // Remember who answers
        end else if (rsp_done) begin
            busy_q    <= 1'b0;          // Next request from the following cycle
        end
    end
end

//------------------------------------------------------------
// Checks
//------------------------------------------------------------
a_one_target: assert property (
    @(posedge core_clk_i) disable iff (!arst_n_i)
    !(tmr_req_o && bus_req_o)
) else $error("router raised req toward both targets");

// A target answers only for a transaction the router handed it
a_tmr_rsp_owned: assert property (
    @(posedge core_clk_i) disable iff (!arst_n_i)
    (tmr_rsp_i.resp != scr1_mem_pkg::MEM_RESP_NOTRDY) |-> (busy_q && sel_tmr_q)
) else $error("timer response without outstanding request");

a_bus_rsp_owned: assert property (
    @(posedge core_clk_i) disable iff (!arst_n_i)
    (bus_rsp_i.resp != scr1_mem_pkg::MEM_RESP_NOTRDY) |-> (busy_q && !sel_tmr_q)
) else $error("bridge response without outstanding request");

endmodule : dmem_router

// File: src/mtimer.sv
// Memory-mapped machine timer
// Enable bit, 64-bit mtime and mtimecmp, registered interrupt

`timescale 1ns/1ns

module mtimer (
    input  logic                    core_clk_i,
    input  logic                    arst_n_i,
    // Register access port
    input  logic                    req_i,
    input  scr1_mem_pkg::dmem_req_t pl_i,
    output logic                    req_ack_o,
    output scr1_mem_pkg::dmem_rsp_t rsp_o,
    // Timer outputs
    output scr1_mem_pkg::mtime_t    timer_val_o,
    output logic                    timer_irq_o
);

logic                      en_q;        // Counter enable
scr1_mem_pkg::mtime_t      mtime_q;
scr1_mem_pkg::mtime_t      mtimecmp_q;
logic                      irq_q;
scr1_mem_pkg::mem_resp_e   resp_q;
scr1_mem_pkg::dmem_data_t  rdata_q;

logic [4:0]                ofs;         // Offset inside the window
logic                      ofs_vld;     // Offset is a real register
logic                      acc_ok;
logic                      wr_en;
scr1_mem_pkg::dmem_data_t  rd_val;

assign req_ack_o = 1'b1;                // Always ready
assign ofs       = pl_i.addr[4:0];

//------------------------------------------------------------
// Register decode and read mux
//------------------------------------------------------------
always_comb begin
    ofs_vld = 1'b1;
    rd_val  = '0;
    case (ofs)
        scr1_mem_pkg::TIMER_OFS_CTRL:        rd_val = {31'd0, en_q};
        scr1_mem_pkg::TIMER_OFS_MTIME_LO:    rd_val = mtime_q[31:0];
        scr1_mem_pkg::TIMER_OFS_MTIME_HI:    rd_val = mtime_q[63:32];
        scr1_mem_pkg::TIMER_OFS_MTIMECMP_LO: rd_val = mtimecmp_q[31:0];
        scr1_mem_pkg::TIMER_OFS_MTIMECMP_HI: rd_val = mtimecmp_q[63:32];
        default:                             ofs_vld = 1'b0;   // Hole in the map
    endcase
end

// Only word accesses to mapped offsets are legal
assign acc_ok = ofs_vld & (pl_i.width == scr1_mem_pkg::MEM_WIDTH_WORD);
assign wr_en  = req_i & acc_ok & (pl_i.cmd == scr1_mem_pkg::MEM_CMD_WR);

//------------------------------------------------------------
// Timer state
//------------------------------------------------------------
always_ff @(posedge core_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
        en_q       <= 1'b0;
        mtime_q    <= scr1_mem_pkg::MTIME_RST;
        mtimecmp_q <= scr1_mem_pkg::MTIMECMP_RST;
        irq_q      <= 1'b0;
        resp_q     <= scr1_mem_pkg::MEM_RESP_NOTRDY;
    end else begin
        // One-cycle response pulse
        if (req_i) begin
            resp_q <= acc_ok ? scr1_mem_pkg::MEM_RESP_RDY_OK
                             : scr1_mem_pkg::MEM_RESP_RDY_ER;
        end else begin
            resp_q <= scr1_mem_pkg::MEM_RESP_NOTRDY;
        end

        if (wr_en && ofs == scr1_mem_pkg::TIMER_OFS_CTRL) begin
            en_q <= pl_i.wdata[0];
        end

        // Write beats increment
        if (wr_en && ofs == scr1_mem_pkg::TIMER_OFS_MTIME_LO) begin
            mtime_q <= {mtime_q[63:32], pl_i.wdata};
        end else if (wr_en && ofs == scr1_mem_pkg::TIMER_OFS_MTIME_HI) begin
            mtime_q <= {pl_i.wdata, mtime_q[31:0]};
        end else if (en_q) begin
            mtime_q <= mtime_q + 64'd1;
        end

        if (wr_en && ofs == scr1_mem_pkg::TIMER_OFS_MTIMECMP_LO) begin
            mtimecmp_q <= {mtimecmp_q[63:32], pl_i.wdata};
        end else if (wr_en && ofs == scr1_mem_pkg::TIMER_OFS_MTIMECMP_HI) begin
            mtimecmp_q <= {pl_i.wdata, mtimecmp_q[31:0]};
        end

        irq_q <= (mtime_q >= mtimecmp_q);   // Level, one cycle behind
    end
end

// Read data, zero for writes and errors
always_ff @(posedge core_clk_i) begin
    if (req_i) begin
        rdata_q <= (acc_ok && pl_i.cmd == scr1_mem_pkg::MEM_CMD_RD) ? rd_val : '0;
    end
end

always_comb begin
    rsp_o.rdata = rdata_q;
    rsp_o.resp  = resp_q;
end

assign timer_val_o = mtime_q;
assign timer_irq_o = irq_q;

// Response only right after an accepted request
a_rsp_after_req: assert property (
    @(posedge core_clk_i) disable iff (!arst_n_i)
    (rsp_o.resp != scr1_mem_pkg::MEM_RESP_NOTRDY) |-> $past(req_i)
) else $error("timer response without a request in the previous cycle");

endmodule : mtimer

// File: src/wb_dmem_bridge.sv
// Data memory to Wishbone classic bridge
// Request capture, byte lane select, one bus cycle per request

`timescale 1ns/1ns

module wb_dmem_bridge (
    input  logic                    core_clk_i,
    input  logic                    arst_n_i,
    // Request port from the router
    input  logic                    req_i,
    input  scr1_mem_pkg::dmem_req_t pl_i,
    output logic                    req_ack_o,
    output scr1_mem_pkg::dmem_rsp_t rsp_o,
    // Wishbone master
    output scr1_mem_pkg::wb_m2s_t   wb_o,
    input  scr1_mem_pkg::wb_s2m_t   wb_i
);

scr1_mem_pkg::bridge_state_e state_q;
scr1_mem_pkg::byte_sel_t     sel_d;     // Lanes for the incoming request
scr1_mem_pkg::dmem_data_t    dat_d;     // Write data spread over lanes
scr1_mem_pkg::dmem_addr_t    adr_q;
logic                        we_q;
scr1_mem_pkg::dmem_data_t    dat_q;
scr1_mem_pkg::byte_sel_t     sel_q;
scr1_mem_pkg::dmem_data_t    rdata_q;
logic                        err_q;
logic                        bus_end;   // ack or err seen

assign req_ack_o = (state_q == scr1_mem_pkg::BR_IDLE);
assign bus_end   = wb_i.ack | wb_i.err;

//------------------------------------------------------------
// Lane select and data replication
//------------------------------------------------------------
always_comb begin
    case (pl_i.width)
        scr1_mem_pkg::MEM_WIDTH_BYTE: begin
            sel_d = 4'b0001 << pl_i.addr[1:0];
            dat_d = {4{pl_i.wdata[7:0]}};
        end
        scr1_mem_pkg::MEM_WIDTH_HWORD: begin
            sel_d = pl_i.addr[1] ? 4'b1100 : 4'b0011;
            dat_d = {2{pl_i.wdata[15:0]}};
        end
        default: begin                  // Full word
            sel_d = 4'b1111;
            dat_d = pl_i.wdata;
        end
    endcase
end

//------------------------------------------------------------
// FSM
//------------------------------------------------------------
always_ff @(posedge core_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
        state_q <= scr1_mem_pkg::BR_IDLE;
    end else begin
        case (state_q)
            scr1_mem_pkg::BR_IDLE: if (req_i)   state_q <= scr1_mem_pkg::BR_BUS;
            scr1_mem_pkg::BR_BUS:  if (bus_end) state_q <= scr1_mem_pkg::BR_RESP;
            default:                            state_q <= scr1_mem_pkg::BR_IDLE;
        endcase
    end
end

// Bus fields and returned data
always_ff @(posedge core_clk_i) begin
    if (state_q == scr1_mem_pkg::BR_IDLE && req_i) begin
        adr_q <= {pl_i.addr[31:2], 2'b00};          // Word aligned
        we_q  <= (pl_i.cmd == scr1_mem_pkg::MEM_CMD_WR);
        dat_q <= dat_d;
        sel_q <= sel_d;
    end
    if (state_q == scr1_mem_pkg::BR_BUS && bus_end) begin
        rdata_q <= wb_i.dat;            // Unshifted
        err_q   <= wb_i.err;            // err wins over ack
    end
end

always_comb begin
    wb_o.stb    = (state_q == scr1_mem_pkg::BR_BUS);
    wb_o.we     = we_q;
    wb_o.adr    = adr_q;
    wb_o.dat    = dat_q;
    wb_o.sel    = sel_q;
    rsp_o.rdata = rdata_q;
    if (state_q != scr1_mem_pkg::BR_RESP) begin
        rsp_o.resp = scr1_mem_pkg::MEM_RESP_NOTRDY;
    end else begin
        rsp_o.resp = err_q ? scr1_mem_pkg::MEM_RESP_RDY_ER : scr1_mem_pkg::MEM_RESP_RDY_OK;
    end
end

// Classic cycle: master holds everything until the slave ends it
a_wb_hold: assert property (
    @(posedge core_clk_i) disable iff (!arst_n_i)
    (wb_o.stb && !bus_end) |=> (wb_o.stb && $stable(wb_o))
) else $error("Wishbone fields changed before ack or err");

endmodule : wb_dmem_bridge

// File: src/dmem_subsys_top.sv
// Data memory subsystem top level
// Router in front of the machine timer and the Wishbone bridge

`timescale 1ns/1ns

module dmem_subsys_top (
    input  logic                    core_clk_i,
    input  logic                    arst_n_i,
    // Core data port
    input  logic                    dmem_req_i,
    input  scr1_mem_pkg::dmem_req_t dmem_req_pl_i,
    output logic                    dmem_req_ack_o,
    output scr1_mem_pkg::dmem_rsp_t dmem_rsp_o,
    // External Wishbone bus
    output scr1_mem_pkg::wb_m2s_t   wb_o,
    input  scr1_mem_pkg::wb_s2m_t   wb_i,
    // Machine timer
    output scr1_mem_pkg::mtime_t    timer_val_o,
    output logic                    timer_irq_o
);

//------------------------------------------------------------
// Router to target wiring
//------------------------------------------------------------
scr1_mem_pkg::dmem_req_t tgt_pl;        // Common payload
logic                    tmr_req;
logic                    tmr_req_ack;
scr1_mem_pkg::dmem_rsp_t tmr_rsp;
logic                    bus_req;
logic                    bus_req_ack;
scr1_mem_pkg::dmem_rsp_t bus_rsp;

dmem_router i_dmem_router (
    .core_clk_i     (core_clk_i    ),
    .arst_n_i       (arst_n_i      ),
    .core_req_i     (dmem_req_i    ),
    .core_pl_i      (dmem_req_pl_i ),
    .core_req_ack_o (dmem_req_ack_o),
    .core_rsp_o     (dmem_rsp_o    ),
    .tgt_pl_o       (tgt_pl        ),
    .tmr_req_o      (tmr_req       ),
    .tmr_req_ack_i  (tmr_req_ack   ),
    .tmr_rsp_i      (tmr_rsp       ),
    .bus_req_o      (bus_req       ),
    .bus_req_ack_i  (bus_req_ack   ),
    .bus_rsp_i      (bus_rsp       )
);

mtimer i_mtimer (
    .core_clk_i     (core_clk_i    ),
    .arst_n_i       (arst_n_i      ),
    .req_i          (tmr_req       ),
    .pl_i           (tgt_pl        ),
    .req_ack_o      (tmr_req_ack   ),
    .rsp_o          (tmr_rsp       ),
    .timer_val_o    (timer_val_o   ),
    .timer_irq_o    (timer_irq_o   )
);

wb_dmem_bridge i_wb_dmem_bridge (
    .core_clk_i     (core_clk_i    ),
    .arst_n_i       (arst_n_i      ),
    .req_i          (bus_req       ),
    .pl_i           (tgt_pl        ),
    .req_ack_o      (bus_req_ack   ),
    .rsp_o          (bus_rsp       ),
    .wb_o           (wb_o          ),
    .wb_i           (wb_i          )
);

endmodule : dmem_subsys_top

// File: verification/wb_slave_model.sv
// Wishbone classic slave memory model
// Random ack delay of 0 to 3 cycles, err for the 0xE region

`timescale 1ns/1ns

module wb_slave_model (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    input  scr1_mem_pkg::wb_m2s_t wb_i,
    output scr1_mem_pkg::wb_s2m_t wb_o
);

integer        seed = 84235;
logic [31:0]   mem [0:255];             // 256 words, adr[9:2]
logic [255:0]  written;                 // Word holds stored data
logic [7:0]    idx;
logic [1:0]    dly_q;                   // Wait states of this cycle
logic [1:0]    cnt_q;                   // Wait states spent so far
logic          done;
logic          err_reg;                 // Top nibble E
logic [31:0]   cur;
logic [31:0]   wr_word;                 // Merged write data

assign idx     = wb_i.adr[9:2];
assign err_reg = (wb_i.adr[31:28] == 4'hE);
assign done    = wb_i.stb && (cnt_q == dly_q);

always_comb begin
    // Unwritten words read as the inverted full address
    cur = written[idx] ? mem[idx] : ~wb_i.adr;
    for (int i = 0; i < 4; i++) begin
        wr_word[8*i +: 8] = wb_i.sel[i] ? wb_i.dat[8*i +: 8] : cur[8*i +: 8];
    end
    wb_o.dat = cur;
    wb_o.ack = done && !err_reg;
    wb_o.err = done &&  err_reg;
end

always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
        dly_q   <= 2'd0;
        cnt_q   <= 2'd0;
        written <= '0;
    end else if (done) begin
        cnt_q <= 2'd0;
        dly_q <= 2'($random(seed) & 3);     // Delay for the next cycle
        if (wb_i.we && !err_reg) begin
            written[idx] <= 1'b1;
        end
    end else if (wb_i.stb) begin
        cnt_q <= cnt_q + 2'd1;
    end
end

always_ff @(posedge clk_i) begin
    if (done && wb_i.we && !err_reg) begin
        mem[idx] <= wr_word;
    end
end

endmodule : wb_slave_model

// File: verification/tb_dmem_subsys.sv
// Testbench for the data memory subsystem
// Clock, reset, access tasks, checking assertions, watchdog

`timescale 1ns/1ns

module tb_dmem_subsys;

localparam int          N_BUS_RAND = 60;
localparam int          N_TRANS    = 35 + N_BUS_RAND;    // All core accesses
localparam logic [31:0] TBASE      = scr1_mem_pkg::TIMER_ADDR_PATTERN;
localparam logic [31:0] BUS_BASE   = 32'h1000_0000;

logic                     clk;
logic                     arst_n;
logic                     req;
scr1_mem_pkg::dmem_req_t  pl;
logic                     ack;
scr1_mem_pkg::dmem_rsp_t  rsp;
scr1_mem_pkg::wb_m2s_t    wb_m2s;
scr1_mem_pkg::wb_s2m_t    wb_s2m;
scr1_mem_pkg::mtime_t     timer_val;
logic                     timer_irq;

string                    test_name;
scr1_mem_pkg::mem_resp_e  exp_resp;
scr1_mem_pkg::dmem_data_t exp_rdata;
logic                     chk_rd;       // Compare read data
scr1_mem_pkg::byte_sel_t  exp_sel;
scr1_mem_pkg::dmem_addr_t exp_adr;
scr1_mem_pkg::mtime_t     exp_mtime;
logic                     mtime_chk;    // Counter stopped so the value is known
scr1_mem_pkg::mtime_t     exp_cmp;
scr1_mem_pkg::dmem_data_t shadow [0:15];    // Expected bus memory words
logic                     pending;      // Accepted and not yet answered
logic                     tmr_hit;
integer                   seed = 84235;

always #4 clk = ~clk;

dmem_subsys_top i_dmem_subsys_top (
    .core_clk_i(clk), .arst_n_i(arst_n), .dmem_req_i(req), .dmem_req_pl_i(pl),
    .dmem_req_ack_o(ack), .dmem_rsp_o(rsp), .wb_o(wb_m2s), .wb_i(wb_s2m),
    .timer_val_o(timer_val), .timer_irq_o(timer_irq)
);

wb_slave_model i_wb_slave_model (.clk_i(clk), .arst_n_i(arst_n), .wb_i(wb_m2s), .wb_o(wb_s2m));

//------------------------------------------------------------
// Failure reporting
//------------------------------------------------------------
task automatic fail_run(input string why);
    $display("%s", why);
    $display("=== FAIL ===");
    $fatal(1, "stopped at first error");
endtask

task automatic value_error(input string name, input logic [63:0] exp, input logic [63:0] act);
    fail_run($sformatf("ERROR %s: expected 0x%0h, actual 0x%0h", name, exp, act));
endtask

// Byte lanes from width and low address bits
function automatic scr1_mem_pkg::byte_sel_t lane_mask(input scr1_mem_pkg::mem_width_e width,
                                                       input scr1_mem_pkg::dmem_addr_t addr);
    int                      size;
    scr1_mem_pkg::byte_sel_t mask;
    size = (width == scr1_mem_pkg::MEM_WIDTH_BYTE)  ? 1 :
           (width == scr1_mem_pkg::MEM_WIDTH_HWORD) ? 2 : 4;
    for (int i = 0; i < 4; i++) begin
        mask[i] = ((i / size) == (addr[1:0] / size));  // Lane inside the accessed unit
    end
    return mask;
endfunction

//------------------------------------------------------------
// Checks
//------------------------------------------------------------
assign tmr_hit = (pl.addr & scr1_mem_pkg::TIMER_ADDR_MASK) == TBASE;

always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) pending <= 1'b0;
    else if (req && ack) pending <= 1'b1;
    else if (rsp.resp != scr1_mem_pkg::MEM_RESP_NOTRDY) pending <= 1'b0;
end

a_reset_idle: assert property (@(posedge clk) $rose(arst_n) |-> (!ack && !wb_m2s.stb
    && rsp.resp == scr1_mem_pkg::MEM_RESP_NOTRDY && !timer_irq))
    else fail_run("outputs not idle after reset release");
a_ack_needs_req: assert property (@(posedge clk) disable iff (!arst_n) !req |-> !ack)
    else fail_run("request ack raised with no request present");
a_single: assert property (@(posedge clk) disable iff (!arst_n) pending |-> !ack)
    else fail_run("second request acked while one is outstanding");
a_rsp_owned: assert property (@(posedge clk) disable iff (!arst_n)
    (rsp.resp != scr1_mem_pkg::MEM_RESP_NOTRDY) |-> pending)
    else fail_run("response without an accepted request");
a_tmr_latency: assert property (@(posedge clk) disable iff (!arst_n)
    (req && ack && tmr_hit) |=> (rsp.resp != scr1_mem_pkg::MEM_RESP_NOTRDY))
    else fail_run("timer response not 1 cycle after acceptance");
a_resp_code: assert property (@(posedge clk) disable iff (!arst_n)
    (rsp.resp != scr1_mem_pkg::MEM_RESP_NOTRDY) |-> (rsp.resp == exp_resp))
    else value_error(test_name, exp_resp, $sampled(rsp.resp));
a_rdata: assert property (@(posedge clk) disable iff (!arst_n)
    (rsp.resp != scr1_mem_pkg::MEM_RESP_NOTRDY && chk_rd) |-> (rsp.rdata == exp_rdata))
    else value_error(test_name, exp_rdata, $sampled(rsp.rdata));
a_wb_sel: assert property (@(posedge clk) disable iff (!arst_n)
    wb_m2s.stb |-> (wb_m2s.sel == exp_sel && wb_m2s.adr == exp_adr))
    else value_error(test_name, {exp_adr, exp_sel}, $sampled({wb_m2s.adr, wb_m2s.sel}));
a_wb_hold: assert property (@(posedge clk) disable iff (!arst_n)
    (wb_m2s.stb && !wb_s2m.ack && !wb_s2m.err) |=> (wb_m2s.stb && $stable(wb_m2s)))
    else fail_run("bus cycle fields changed before ack or err");
a_mtime: assert property (@(posedge clk) disable iff (!arst_n)
    mtime_chk |-> (timer_val == exp_mtime))
    else value_error(test_name, exp_mtime, $sampled(timer_val));
a_irq: assert property (@(posedge clk) disable iff (!arst_n)
    timer_irq |-> ($past(timer_val) >= exp_cmp))
    else fail_run("timer_irq high while mtime was below mtimecmp");

//------------------------------------------------------------
// Stimulus
//------------------------------------------------------------
// Called 1 ns after a rising edge, returns 1 ns after one
task automatic access(input scr1_mem_pkg::mem_cmd_e cmd, input scr1_mem_pkg::mem_width_e width,
                      input scr1_mem_pkg::dmem_addr_t addr, input scr1_mem_pkg::dmem_data_t wdata,
                      input scr1_mem_pkg::mem_resp_e resp, input scr1_mem_pkg::dmem_data_t rexp,
                      input logic hold);
    exp_resp  = resp;
    exp_rdata = rexp;
    chk_rd    = (cmd == scr1_mem_pkg::MEM_CMD_RD) && (resp == scr1_mem_pkg::MEM_RESP_RDY_OK);
    exp_adr   = addr & 32'hFFFF_FFFC;
    exp_sel   = lane_mask(width, addr);
    pl.cmd    = cmd;
    pl.width  = width;
    pl.addr   = addr;
    pl.wdata  = wdata;
    req       = 1'b1;
    do @(negedge clk); while (!ack);    // Accepted at the next edge
    @(posedge clk);
    #1;
    req = hold;                         // Core keeps asking during the wait
    do @(negedge clk); while (rsp.resp == scr1_mem_pkg::MEM_RESP_NOTRDY);
    @(posedge clk);
    #1;
    req = 1'b0;
endtask

task automatic tmr_write(input logic [4:0] ofs, input scr1_mem_pkg::dmem_data_t data);
    access(scr1_mem_pkg::MEM_CMD_WR, scr1_mem_pkg::MEM_WIDTH_WORD, TBASE + ofs, data,
           scr1_mem_pkg::MEM_RESP_RDY_OK, '0, 1'b0);
    case (ofs)
        scr1_mem_pkg::TIMER_OFS_MTIME_LO:    exp_mtime[31:0]  = data;
        scr1_mem_pkg::TIMER_OFS_MTIME_HI:    exp_mtime[63:32] = data;
        scr1_mem_pkg::TIMER_OFS_MTIMECMP_LO: exp_cmp[31:0]    = data;
        scr1_mem_pkg::TIMER_OFS_MTIMECMP_HI: exp_cmp[63:32]   = data;
        default: ;
    endcase
endtask

task automatic tmr_read(input logic [4:0] ofs, input scr1_mem_pkg::dmem_data_t rexp);
    access(scr1_mem_pkg::MEM_CMD_RD, scr1_mem_pkg::MEM_WIDTH_WORD, TBASE + ofs, '0,
           scr1_mem_pkg::MEM_RESP_RDY_OK, rexp, 1'b0);
endtask

task automatic bus_op(input logic wr, input scr1_mem_pkg::mem_width_e width, input int idx,
                      input logic [1:0] boff, input scr1_mem_pkg::dmem_data_t wdata,
                      input logic hold);
    scr1_mem_pkg::dmem_addr_t addr;
    scr1_mem_pkg::byte_sel_t  sel;
    addr  = BUS_BASE + idx * 4 + boff;
    sel   = lane_mask(width, addr);
    access(wr ? scr1_mem_pkg::MEM_CMD_WR : scr1_mem_pkg::MEM_CMD_RD, width, addr, wdata,
           scr1_mem_pkg::MEM_RESP_RDY_OK, shadow[idx], hold);
    // Selected lanes take the low bytes of wdata in order
    for (int i = 0; i < 4; i++) begin
        if (wr && sel[i]) shadow[idx][8*i +: 8] = wdata[8*(i - int'(boff)) +: 8];
    end
endtask

initial begin
    logic [31:0]               rnd;
    scr1_mem_pkg::mem_width_e  width;
    logic [1:0]                boff;
    clk       = 1'b0;
    arst_n    = 1'b0;
    req       = 1'b0;
    pl        = '0;
    test_name = "reset";
    exp_resp  = scr1_mem_pkg::MEM_RESP_NOTRDY;
    exp_rdata = '0;
    chk_rd    = 1'b0;
    exp_sel   = '0;
    exp_adr   = '0;
    exp_mtime = '0;
    mtime_chk = 1'b0;
    exp_cmp   = scr1_mem_pkg::MTIMECMP_RST;
    repeat (5) @(posedge clk);
    #1 arst_n = 1'b1;
    repeat (3) @(posedge clk);          // Idle outputs checked here
    #1;

    test_name = "timer_regs";           // Counter still disabled
    tmr_write(scr1_mem_pkg::TIMER_OFS_MTIMECMP_LO, 32'hFEDC_BA98);
    tmr_write(scr1_mem_pkg::TIMER_OFS_MTIMECMP_HI, 32'h7654_3210);
    tmr_write(scr1_mem_pkg::TIMER_OFS_MTIME_LO, 32'h89AB_CDEF);
    tmr_write(scr1_mem_pkg::TIMER_OFS_MTIME_HI, 32'h0000_1234);
    mtime_chk = 1'b1;
    tmr_read(scr1_mem_pkg::TIMER_OFS_MTIME_LO, 32'h89AB_CDEF);
    tmr_read(scr1_mem_pkg::TIMER_OFS_MTIME_HI, 32'h0000_1234);
    tmr_read(scr1_mem_pkg::TIMER_OFS_MTIMECMP_LO, 32'hFEDC_BA98);
    tmr_read(scr1_mem_pkg::TIMER_OFS_MTIMECMP_HI, 32'h7654_3210);

    test_name = "timer_errors";         // Byte width then unmapped offset
    access(scr1_mem_pkg::MEM_CMD_WR, scr1_mem_pkg::MEM_WIDTH_BYTE, TBASE + 8, 32'h55,
           scr1_mem_pkg::MEM_RESP_RDY_ER, '0, 1'b0);
    access(scr1_mem_pkg::MEM_CMD_WR, scr1_mem_pkg::MEM_WIDTH_WORD, TBASE + 4, 32'h1,
           scr1_mem_pkg::MEM_RESP_RDY_ER, '0, 1'b0);
    tmr_read(scr1_mem_pkg::TIMER_OFS_MTIME_LO, 32'h89AB_CDEF);

    test_name = "irq";
    mtime_chk = 1'b0;
    tmr_write(scr1_mem_pkg::TIMER_OFS_MTIME_LO, 32'd0);
    tmr_write(scr1_mem_pkg::TIMER_OFS_MTIME_HI, 32'd0);
    tmr_write(scr1_mem_pkg::TIMER_OFS_MTIMECMP_LO, 32'd20);
    tmr_write(scr1_mem_pkg::TIMER_OFS_MTIMECMP_HI, 32'd0);
    tmr_write(scr1_mem_pkg::TIMER_OFS_CTRL, 32'd1);
    wait (timer_irq);                   // Rises once mtime reaches 20
    @(posedge clk);
    #1;

    test_name = "bus";
    for (int i = 0; i < 16; i++) begin
        bus_op(1'b1, scr1_mem_pkg::MEM_WIDTH_WORD, i, 2'd0, $random(seed), 1'b0);
    end
    for (int n = 0; n < N_BUS_RAND; n++) begin
        rnd   = $random(seed);
        width = scr1_mem_pkg::mem_width_e'(rnd[9:8] % 3);
        boff  = rnd[7:6];
        if (width == scr1_mem_pkg::MEM_WIDTH_HWORD) boff[0] = 1'b0;
        if (width == scr1_mem_pkg::MEM_WIDTH_WORD)  boff    = 2'd0;
        bus_op(rnd[0], width, int'(rnd[5:2]), boff, $random(seed), rnd[1]);
    end

    test_name = "bus_errors";           // E region then unchanged alias word
    access(scr1_mem_pkg::MEM_CMD_WR, scr1_mem_pkg::MEM_WIDTH_WORD, 32'hE000_0010,
           32'hDEAD_0001, scr1_mem_pkg::MEM_RESP_RDY_ER, '0, 1'b0);
    access(scr1_mem_pkg::MEM_CMD_RD, scr1_mem_pkg::MEM_WIDTH_WORD, 32'hE000_0010, '0,
           scr1_mem_pkg::MEM_RESP_RDY_ER, '0, 1'b1);
    bus_op(1'b0, scr1_mem_pkg::MEM_WIDTH_WORD, 4, 2'd0, '0, 1'b0);

    repeat (2) @(posedge clk);
    $display("=== PASS ===");
    $finish;
end

// Watchdog
initial begin
    repeat (N_TRANS * 10 + 500) @(posedge clk);
    fail_run("watchdog timeout, run did not complete in time");
end

endmodule : tb_dmem_subsys

// File: compile.f
src/scr1_mem_pkg.sv
src/dmem_router.sv
src/mtimer.sv
src/wb_dmem_bridge.sv
src/dmem_subsys_top.sv
verification/wb_slave_model.sv
verification/tb_dmem_subsys.sv

// File: Bender.yml
package:
  name: dmem_subsys

dependencies: {}

sources:
  - src/scr1_mem_pkg.sv
  - src/dmem_router.sv
  - src/mtimer.sv
  - src/wb_dmem_bridge.sv
  - src/dmem_subsys_top.sv
  - target: test
    files:
      - verification/wb_slave_model.sv
      - verification/tb_dmem_subsys.sv
